// File: filelist.f
hdl/hbus_pkg.sv
hdl/hbus_req_decode.sv
hdl/hbus_sequencer.sv
hdl/hbus_read_capture.sv
hdl/hbus_ctrl_top.sv
verification/hbus_ram_model.sv
verification/hbus_checker.sv
verification/hbus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the HyperBus controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hbus_tb -f filelist.f \
    --Mdir obj_dir -o hbus_sim

out=$(./obj_dir/hbus_sim) || true
echo "$out"
echo "$out" | grep -qx "No errors"

// File: verification/hbus_tb.sv
// Testbench for the HyperBus controller with host stimulus and a reference memory
`timescale 1ns/1ns
`default_nettype none

module hbus_tb
    import hbus_pkg::*;
();

    localparam int CMD_DEPTH    = 4;
    localparam int TACC_COUNT   = 5;
    localparam int RESET_COUNT  = 2;
    localparam int READ_TIMEOUT = 16;
    localparam int WAIT_LIMIT   = 200;
    localparam logic [15:0] ID0 = 16'h0c81;

    logic        clk;
    logic        rst;
    logic        req_valid;
    hbus_req_t   req;
    logic        credit;
    logic        rsp_valid;
    hbus_rsp_t   rsp;
    logic        hbus_ck_en;
    logic        hbus_csn;
    logic        hbus_rstn;
    logic [15:0] dq_out;
    logic        dq_oe;
    logic [15:0] dq_in;
    logic [1:0]  rwds_out;
    logic        rwds_oe;
    logic [1:0]  rwds_in;
    logic        dbl_lat;
    logic        no_rsp;
    logic        bus_err;
    logic        exp_push;
    hbus_rsp_t   exp_rsp;
    int          err_count;
    int          rsp_count;
    int          pending;
    int          credits_spent = 0;
    int          credits_returned = 0;
    int          tests_run = 0;
    bit          timed_out = 1'b0;
    logic [31:0] rand_state;
    logic [15:0] ref_mem [16];
    logic [31:0] addrs [8];

    hbus_ctrl_top #(
        .CMD_DEPTH   (CMD_DEPTH),
        .TACC_COUNT  (TACC_COUNT),
        .RESET_COUNT (RESET_COUNT),
        .READ_TIMEOUT(READ_TIMEOUT)
    ) i_dut (
        .clk(clk), .rst(rst), .req_valid_i(req_valid), .req_i(req),
        .credit_o(credit), .rsp_valid_o(rsp_valid), .rsp_o(rsp),
        .hbus_ck_en_o(hbus_ck_en), .hbus_csn_o(hbus_csn), .hbus_rstn_o(hbus_rstn),
        .hbus_dq_o(dq_out), .hbus_dq_oe_o(dq_oe), .hbus_dq_i(dq_in),
        .hbus_rwds_o(rwds_out), .hbus_rwds_oe_o(rwds_oe), .hbus_rwds_i(rwds_in)
    );

    hbus_ram_model #(.TACC_COUNT(TACC_COUNT)) i_ram (
        .clk(clk), .rst(rst), .dbl_lat_i(dbl_lat), .no_rsp_i(no_rsp),
        .csn_i(hbus_csn), .ck_en_i(hbus_ck_en),
        .dq_i(dq_out), .dq_oe_i(dq_oe), .rwds_i(rwds_out), .rwds_oe_i(rwds_oe),
        .dq_o(dq_in), .rwds_o(rwds_in), .bus_err_o(bus_err)
    );

    hbus_checker #(.CMD_DEPTH(CMD_DEPTH), .RESET_COUNT(RESET_COUNT)) i_checker (
        .clk(clk), .rst(rst), .seq_state_i(i_dut.i_sequencer.state),
        .hbus_rstn_i(hbus_rstn), .hbus_csn_i(hbus_csn), .req_valid_i(req_valid),
        .credit_i(credit), .rsp_valid_i(rsp_valid), .rsp_i(rsp),
        .exp_push_i(exp_push), .exp_rsp_i(exp_rsp), .bus_err_i(bus_err),
        .err_count_o(err_count), .rsp_count_o(rsp_count), .pending_o(pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && credit) credits_returned++;
    end

    function automatic int credits_avail();
        return CMD_DEPTH - credits_spent + credits_returned;
    endfunction

    // Idle means device out of reset, all credits home, no read outstanding and chip select high
    function automatic bit bus_idle();
        return hbus_rstn === 1'b1 && hbus_csn && pending == 0 &&
               credits_avail() == CMD_DEPTH;
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Reference memory, a set mask bit keeps the old byte
    function automatic logic [15:0] ref_access(input hbus_op_e op, input logic reg_sp,
                                               input logic [31:0] addr, input logic [15:0] wdata,
                                               input logic [1:0] wmask);
        logic [15:0] old;
        old = ref_mem[addr[3:0]];
        if (reg_sp) return ID0;
        if (op == OP_WRITE) begin
            ref_mem[addr[3:0]] = {wmask[1] ? old[15:8] : wdata[15:8],
                                  wmask[0] ? old[7:0]  : wdata[7:0]};
        end
        return old;
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic send_req(input hbus_op_e op, input logic reg_sp, input logic [31:0] addr,
                            input logic [15:0] wdata, input logic [1:0] wmask,
                            input logic timeout_expected);
        logic [15:0] predicted;
        int          waited;
        waited = 0;
        while (credits_avail() == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (credits_avail() == 0) begin
            note_timeout("no credit came back from the controller");
        end else begin
            predicted     = ref_access(op, reg_sp, addr, wdata, wmask);
            req.op        = op;
            req.reg_space = reg_sp;
            req.addr      = addr;
            req.wdata     = wdata;
            req.wmask     = wmask;
            req_valid     = 1'b1;
            credits_spent++;
            if (op == OP_READ) begin
                exp_rsp.rdata   = timeout_expected ? 16'h0000 : predicted;
                exp_rsp.timeout = timeout_expected;
                exp_push        = 1'b1;
            end
            @(negedge clk);
            req_valid = 1'b0;
            exp_push  = 1'b0;
        end
    endtask

    task automatic random_write(output logic [31:0] addr);
        logic [31:0] r;
        logic [31:0] d;
        r    = next_random();
        d    = next_random();
        addr = {28'h0, r[27:24]};
        send_req(OP_WRITE, 1'b0, addr, d[31:16], r[21:20], 1'b0);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!bus_idle() && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_idle()) begin
            note_timeout("controller did not return to idle");
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %0d %s finished, errors so far %0d", tests_run, name, err_count);
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        exp_push   = 1'b0;
        exp_rsp    = '0;
        dbl_lat    = 1'b0;
        no_rsp     = 1'b0;
        rand_state = 32'h06a7_e5f0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i[3:0]] = {i[3:0], 4'h3, ~i[3:0], 4'hc};
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wait_idle();
        report_test("device reset");

        for (int i = 0; i < 8; i++) random_write(addrs[i]);
        for (int i = 0; i < 8; i++) send_req(OP_READ, 1'b0, addrs[i], 16'h0, 2'b00, 1'b0);
        wait_idle();
        report_test("masked writes and reads");

        send_req(OP_READ, 1'b1, 32'h0, 16'h0, 2'b00, 1'b0);
        send_req(OP_READ, 1'b1, 32'h0, 16'h0, 2'b00, 1'b0);
        wait_idle();
        report_test("register reads");

        dbl_lat = 1'b1;
        for (int i = 0; i < 3; i++) random_write(addrs[i]);
        for (int i = 0; i < 3; i++) send_req(OP_READ, 1'b0, addrs[i], 16'h0, 2'b00, 1'b0);
        wait_idle();
        dbl_lat = 1'b0;
        report_test("double latency");

        no_rsp = 1'b1;
        send_req(OP_READ, 1'b0, addrs[0], 16'h0, 2'b00, 1'b1);
        wait_idle();
        no_rsp = 1'b0;
        send_req(OP_READ, 1'b0, addrs[0], 16'h0, 2'b00, 1'b0);
        wait_idle();
        report_test("read timeout");

        random_write(addrs[0]);
        send_req(OP_READ, 1'b0, addrs[0], 16'h0, 2'b00, 1'b0);
        random_write(addrs[1]);
        send_req(OP_READ, 1'b0, addrs[1], 16'h0, 2'b00, 1'b0);
        wait_idle();
        report_test("back to back requests");

        $display("Done: %0d tests, %0d responses checked, %0d errors",
                 tests_run, rsp_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/hbus_checker.sv
// Scoreboard checking the device reset phase, host credits and read responses
`timescale 1ns/1ns
`default_nettype none

module hbus_checker
    import hbus_pkg::*;
#(
    parameter int CMD_DEPTH   = 4,
    parameter int RESET_COUNT = 2
) (
    input  wire             clk,
    input  wire             rst,
    input  wire seq_state_e seq_state_i,
    input  wire             hbus_rstn_i,
    input  wire             hbus_csn_i,
    input  wire             req_valid_i,
    input  wire             credit_i,
    input  wire             rsp_valid_i,
    input  wire hbus_rsp_t  rsp_i,
    input  wire             exp_push_i,
    input  wire hbus_rsp_t  exp_rsp_i,
    input  wire             bus_err_i,
    output int              err_count_o,
    output int              rsp_count_o,
    output int              pending_o
);

    hbus_rsp_t exp_q [$];
    hbus_rsp_t exp;
    int        errors = 0;
    int        checked = 0;
    int        pending = 0;
    int        credits = CMD_DEPTH;
    int        rst_cycles = 0;
    bit        reset_done = 1'b0;

    assign err_count_o = errors;
    assign rsp_count_o = checked;
    assign pending_o   = pending;

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            credits    = CMD_DEPTH;
            rst_cycles = 0;
            reset_done = 1'b0;
        end else begin
            if (seq_state_i == ST_RESET) begin
                rst_cycles++;
                if (hbus_rstn_i !== 1'b0) begin
                    $display("** Error: hbus_rstn_o = %h in device reset, expected 0", hbus_rstn_i);
                    errors++;
                end
                if (hbus_csn_i !== 1'b1 || credit_i !== 1'b0) begin
                    $display("** Error: hbus_csn_o = %h, credit_o = %h in device reset, expected 1, 0",
                             hbus_csn_i, credit_i);
                    errors++;
                end
            end else begin
                if (!reset_done && rst_cycles != RESET_COUNT + 1) begin
                    $display("** Error: hbus_rstn_o low for %h cycles, expected %h",
                             rst_cycles, RESET_COUNT + 1);
                    errors++;
                end
                reset_done = 1'b1;
                if (hbus_rstn_i !== 1'b1) begin
                    $display("** Error: hbus_rstn_o = %h after device reset, expected 1", hbus_rstn_i);
                    errors++;
                end
            end

            // Host credits never leave the range 0 to CMD_DEPTH
            if (req_valid_i) credits--;
            if (credit_i) credits++;
            if (credits < 0 || credits > CMD_DEPTH) begin
                $display("Credit count out of range: %0d credits held by the host", credits);
                errors++;
            end

            if (exp_push_i) exp_q.push_back(exp_rsp_i);
            if (rsp_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("Response arrived with no read outstanding");
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    checked++;
                    if (rsp_i.rdata !== exp.rdata) begin
                        $display("** Error: rsp_o.rdata = %h, expected %h", rsp_i.rdata, exp.rdata);
                        errors++;
                    end
                    if (rsp_i.timeout !== exp.timeout) begin
                        $display("** Error: rsp_o.timeout = %h, expected %h",
                                 rsp_i.timeout, exp.timeout);
                        errors++;
                    end
                end
            end
            if (bus_err_i) errors++;
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: verification/hbus_ram_model.sv
// HyperRAM device model on the split DDR bus with a small memory and the ID0 register
`timescale 1ns/1ns
`default_nettype none

module hbus_ram_model
    import hbus_pkg::*;
#(
    parameter int TACC_COUNT = 5
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         dbl_lat_i,
    input  wire         no_rsp_i,
    input  wire         csn_i,
    input  wire         ck_en_i,
    input  wire  [15:0] dq_i,
    input  wire         dq_oe_i,
    input  wire  [1:0]  rwds_i,
    input  wire         rwds_oe_i,
    output logic [15:0] dq_o,
    output logic [1:0]  rwds_o,
    output logic        bus_err_o
);

    localparam logic [15:0] ID0 = 16'h0c81;

    logic [15:0] mem [16];
    hbus_ca_t    ca_q;
    int          cyc;
    int          lat;
    int          data_cyc;
    logic [3:0]  idx;
    logic        read_now;
    logic        err_now;

    assign lat      = dbl_lat_i ? 2 * TACC_COUNT : TACC_COUNT;
    assign data_cyc = 3 + lat;
    assign idx      = {ca_q.row_addr[0], ca_q.col_addr};
    assign read_now = !csn_i && ca_q.rw && (cyc == data_cyc) && !no_rsp_i;

    // RWDS high through the command asks for double latency
    assign dq_o   = read_now ? (ca_q.addr_space ? ID0 : mem[idx]) : 16'h0000;
    assign rwds_o = (!csn_i && cyc < 3) ? {2{dbl_lat_i}} : (read_now ? 2'b10 : 2'b00);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc       <= 0;
            ca_q      <= '0;
            bus_err_o <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem[i[3:0]] <= {i[3:0], 4'h3, ~i[3:0], 4'hc};
            end
        end else begin
            err_now = 1'b0;
            if (csn_i) begin
                cyc <= 0;
                if (ck_en_i || dq_oe_i || rwds_oe_i) begin
                    $display("Device model: clock or bus active while chip select is high");
                    err_now = 1'b1;
                end
            end else begin
                cyc <= cyc + 1;
                if (!ck_en_i) begin
                    $display("Device model: clock stopped while chip select is low, bus cycle %0d",
                             cyc);
                    err_now = 1'b1;
                end
                if (cyc < 3) begin
                    if (!dq_oe_i) begin
                        $display("Device model: command word not driven, bus cycle %0d", cyc);
                        err_now = 1'b1;
                    end
                    case (cyc)
                        0:       ca_q[47:32] <= dq_i;
                        1:       ca_q[31:16] <= dq_i;
                        default: ca_q[15:0]  <= dq_i;
                    endcase
                end
                if (cyc == 3 && (!ca_q.burst_linear || ca_q.reserved != '0 ||
                                 ca_q.row_addr[28:1] != '0)) begin
                    $display("** Error: hbus_dq_o command word = %h, bad field", ca_q);
                    err_now = 1'b1;
                end
                if (cyc >= 3 && (dq_oe_i || rwds_oe_i) && !(!ca_q.rw && cyc == data_cyc)) begin
                    $display("Device model: DQ driven outside the write data cycle, bus cycle %0d",
                             cyc);
                    err_now = 1'b1;
                end
                if (!ca_q.rw && cyc == data_cyc) begin
                    if (!dq_oe_i || !rwds_oe_i) begin
                        $display("Device model: write data missing after the latency");
                        err_now = 1'b1;
                    end else if (!ca_q.addr_space) begin
                        mem[idx] <= {rwds_i[1] ? mem[idx][15:8] : dq_i[15:8],
                                     rwds_i[0] ? mem[idx][7:0]  : dq_i[7:0]};
                    end
                end
                if (!ca_q.rw && cyc > data_cyc) begin
                    $display("Device model: chip select still low after the write data");
                    err_now = 1'b1;
                end
            end
            bus_err_o <= err_now;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hbus_ctrl_top.sv
// HyperBus controller top joining request decode, bus sequencer and read capture
`timescale 1ns/1ns
`default_nettype none

module hbus_ctrl_top
    import hbus_pkg::*;
#(
    parameter int CMD_DEPTH    = 4,
    parameter int TACC_COUNT   = 5,
    parameter int RESET_COUNT  = 2,
    parameter int READ_TIMEOUT = 16
) (
    input  wire         clk,
    input  wire         rst,
    // Host side
    input  wire         req_valid_i,
    input  wire         hbus_req_t req_i,
    output logic        credit_o,
    output logic        rsp_valid_o,
    output hbus_rsp_t   rsp_o,
    // Split DDR bus, two half-cycles per clk
    output logic        hbus_ck_en_o,
    output logic        hbus_csn_o,
    output logic        hbus_rstn_o,
    output logic [15:0] hbus_dq_o,
    output logic        hbus_dq_oe_o,
    input  wire  [15:0] hbus_dq_i,
    output logic [1:0]  hbus_rwds_o,
    output logic        hbus_rwds_oe_o,
    input  wire  [1:0]  hbus_rwds_i
);

    logic      cmd_valid;
    logic      cmd_take;
    hbus_cmd_t cmd;
    logic      rd_window;
    logic      rd_done;

    hbus_req_decode #(
        .CMD_DEPTH(CMD_DEPTH)
    ) i_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .req_i      (req_i),
        .cmd_take_i (cmd_take),
        .cmd_valid_o(cmd_valid),
        .cmd_o      (cmd),
        .credit_o   (credit_o)
    );

    hbus_sequencer #(
        .TACC_COUNT (TACC_COUNT),
        .RESET_COUNT(RESET_COUNT)
    ) i_sequencer (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid_i   (cmd_valid),
        .cmd_i         (cmd),
        .hbus_rwds_i   (hbus_rwds_i),
        .rd_done_i     (rd_done),
        .cmd_take_o    (cmd_take),
        .rd_window_o   (rd_window),
        .hbus_ck_en_o  (hbus_ck_en_o),
        .hbus_csn_o    (hbus_csn_o),
        .hbus_rstn_o   (hbus_rstn_o),
        .hbus_dq_o     (hbus_dq_o),
        .hbus_dq_oe_o  (hbus_dq_oe_o),
        .hbus_rwds_o   (hbus_rwds_o),
        .hbus_rwds_oe_o(hbus_rwds_oe_o)
    );

    hbus_read_capture #(
        .READ_TIMEOUT(READ_TIMEOUT)
    ) i_read_capture (
        .clk        (clk),
        .rst        (rst),
        .rd_window_i(rd_window),
        .hbus_dq_i  (hbus_dq_i),
        .hbus_rwds_i(hbus_rwds_i),
        .rd_done_o  (rd_done),
        .rsp_valid_o(rsp_valid_o),
        .rsp_o      (rsp_o)
    );

endmodule

`default_nettype wire

// File: hdl/hbus_read_capture.sv
// Read capture taking the strobed DQ word or reporting a read timeout
`timescale 1ns/1ns
`default_nettype none

module hbus_read_capture
    import hbus_pkg::*;
#(
    parameter int READ_TIMEOUT = 16
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        rd_window_i,
    input  wire [15:0] hbus_dq_i,
    input  wire [1:0]  hbus_rwds_i,
    output logic       rd_done_o,
    output logic       rsp_valid_o,
    output hbus_rsp_t  rsp_o
);

    localparam int TMO_W = $clog2(READ_TIMEOUT + 1);

    logic [TMO_W-1:0] wait_cnt;
    logic             done_q;
    logic             armed;
    logic             strobe;
    logic             expired;

    // Valid strobe is high on the first half cycle, low on the second
    assign strobe  = (hbus_rwds_i == 2'b10);
    assign expired = (wait_cnt == TMO_W'(READ_TIMEOUT - 1));
    // Window stays open one cycle after done while the sequencer reacts
    assign armed   = rd_window_i && !done_q;

    assign rd_done_o   = done_q;
    assign rsp_valid_o = done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= armed && (strobe || expired);
            if (armed && !strobe && !expired) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (armed && strobe) begin
            rsp_o.rdata   <= hbus_dq_i;
            rsp_o.timeout <= 1'b0;
        end else if (armed && expired) begin
            rsp_o.rdata   <= 16'h0000;
            rsp_o.timeout <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hbus_sequencer.sv
// HyperBus sequencer driving device reset, command, latency and single-word transfers
`timescale 1ns/1ns
`default_nettype none

module hbus_sequencer
    import hbus_pkg::*;
#(
    parameter int TACC_COUNT  = 5,
    parameter int RESET_COUNT = 2
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         cmd_valid_i,
    input  wire         hbus_cmd_t cmd_i,
    input  wire  [1:0]  hbus_rwds_i,
    input  wire         rd_done_i,
    output logic        cmd_take_o,
    output logic        rd_window_o,
    output logic        hbus_ck_en_o,
    output logic        hbus_csn_o,
    output logic        hbus_rstn_o,
    output logic [15:0] hbus_dq_o,
    output logic        hbus_dq_oe_o,
    output logic [1:0]  hbus_rwds_o,
    output logic        hbus_rwds_oe_o
);

    // Counter must cover the reset length and the doubled latency
    localparam int CNT_MAX = (2 * TACC_COUNT > RESET_COUNT) ? 2 * TACC_COUNT : RESET_COUNT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    seq_state_e       state;
    logic [CNT_W-1:0] count;
    logic             extra_lat;
    logic             rwds_high;
    logic             bus_active;
    logic [47:0]      ca_sr;
    hbus_op_e         op_q;
    logic [15:0]      wdata_q;
    logic [1:0]       wmask_q;

    // Device asks for double latency by holding RWDS high during CA
    assign rwds_high   = (hbus_rwds_i == 2'b11);
    assign cmd_take_o  = (state == ST_IDLE) && cmd_valid_i;
    assign rd_window_o = (state == ST_READ);
    assign bus_active  = state inside {ST_COMMAND, ST_LATENCY, ST_WRITE, ST_READ};

    assign hbus_ck_en_o = bus_active;
    assign hbus_csn_o   = !bus_active;
    assign hbus_rstn_o  = (state != ST_RESET);

    always_comb begin
        hbus_dq_o      = 16'h0000;
        hbus_dq_oe_o   = 1'b0;
        hbus_rwds_o    = 2'b00;
        hbus_rwds_oe_o = 1'b0;
        case (state)
            ST_COMMAND: begin
                hbus_dq_o    = ca_sr[47:32];
                hbus_dq_oe_o = 1'b1;
            end
            ST_WRITE: begin
                hbus_dq_o      = wdata_q;
                hbus_dq_oe_o   = 1'b1;
                hbus_rwds_o    = wmask_q;
                hbus_rwds_oe_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Command payload, CA shifts up one word per command cycle
    always_ff @(posedge clk) begin
        if (cmd_take_o) begin
            ca_sr   <= cmd_i.ca;
            op_q    <= cmd_i.op;
            wdata_q <= cmd_i.wdata;
            wmask_q <= cmd_i.wmask;
        end else if (state == ST_COMMAND) begin
            ca_sr <= ca_sr << 16;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_RESET;
            count     <= CNT_W'(RESET_COUNT);
            extra_lat <= 1'b0;
        end else begin
            case (state)
                ST_RESET: begin
                    if (count == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (cmd_take_o) begin
                        // Three cycles for 48 bits of CA
                        count     <= CNT_W'(2);
                        extra_lat <= 1'b0;
                        state     <= ST_COMMAND;
                    end
                end
                ST_COMMAND: begin
                    extra_lat <= extra_lat | rwds_high;
                    if (count == '0) begin
                        count <= (extra_lat || rwds_high) ? CNT_W'(2 * TACC_COUNT - 1)
                                                          : CNT_W'(TACC_COUNT - 1);
                        state <= ST_LATENCY;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                ST_LATENCY: begin
                    if (count == '0) begin
                        state <= (op_q == OP_READ) ? ST_READ : ST_WRITE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                ST_WRITE: state <= ST_RECOVER;
                ST_READ: begin
                    if (rd_done_i) begin
                        state <= ST_RECOVER;
                    end
                end
                ST_RECOVER: state <= ST_IDLE;
                default: begin
                    count <= CNT_W'(RESET_COUNT);
                    state <= ST_RESET;
                end
            endcase
        end
    end

    // Chip select stays high in reset and idle and in the cycle before them
    a_csn_high_idle: assert property (
        @(posedge clk) disable iff (rst) (state inside {ST_RESET, ST_IDLE})
            |-> (hbus_csn_o && !hbus_ck_en_o && $past(hbus_csn_o))
    ) else $error("hbus_sequencer: chip select active outside a transaction");

    // Device owns DQ and RWDS for the whole read and the bus is released a cycle before it
    a_no_drive_in_read: assert property (
        @(posedge clk) disable iff (rst) (state == ST_READ)
            |-> !(hbus_dq_oe_o || hbus_rwds_oe_o || $past(hbus_dq_oe_o))
    ) else $error("hbus_sequencer: bus driven during read");

endmodule

`default_nettype wire

// File: hdl/hbus_req_decode.sv
// Request decoder holding host requests in a credit-counted FIFO and forming CA words
`timescale 1ns/1ns
`default_nettype none

module hbus_req_decode
    import hbus_pkg::*;
#(
    parameter int CMD_DEPTH = 4
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid_i,
    input  wire       hbus_req_t req_i,
    input  wire       cmd_take_i,
    output logic      cmd_valid_o,
    output hbus_cmd_t cmd_o,
    output logic      credit_o
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    hbus_cmd_t        mem [CMD_DEPTH];
    hbus_cmd_t        new_cmd;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    // Build the command from the request
    always_comb begin
        new_cmd                 = '0;
        new_cmd.op              = req_i.op;
        new_cmd.ca.rw           = (req_i.op == OP_READ);
        new_cmd.ca.addr_space   = req_i.reg_space;
        new_cmd.ca.burst_linear = 1'b1;
        new_cmd.ca.row_addr     = req_i.addr[31:3];
        new_cmd.ca.reserved     = 13'd0;
        new_cmd.ca.col_addr     = req_i.addr[2:0];
        new_cmd.wdata           = req_i.wdata;
        new_cmd.wmask           = req_i.wmask;
    end

    assign full        = (count == CNT_W'(CMD_DEPTH));
    assign cmd_valid_o = (count != '0);
    assign pop         = cmd_take_i && cmd_valid_o;
    assign push        = req_valid_i && (!full || pop);
    assign cmd_o       = mem[rd_ptr];
    // Each entry handed to the sequencer returns one credit
    assign credit_o    = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= new_cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Host credit accounting must keep requests out of a full FIFO
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) (req_valid_i && full) |-> pop
    ) else $error("hbus_req_decode: request without credit, FIFO full");

endmodule

`default_nettype wire

// File: hdl/hbus_pkg.sv
// HyperBus controller package with opcodes, sequencer states and transaction structs
`default_nettype none

package hbus_pkg;

    // Host opcode, encoded to match the CA read/write bit
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } hbus_op_e;

    // Host request as presented on the credit channel
    typedef struct packed {
        hbus_op_e    op;
        logic        reg_space;
        logic [31:0] addr;
        logic [15:0] wdata;
        // Set bit leaves that byte untouched
        logic [1:0]  wmask;
    } hbus_req_t;

    // 48-bit command/address word, sent upper half first
    typedef struct packed {
        logic        rw;
        logic        addr_space;
        logic        burst_linear;
        logic [28:0] row_addr;
        logic [12:0] reserved;
        logic [2:0]  col_addr;
    } hbus_ca_t;

    typedef struct packed {
        hbus_op_e    op;
        hbus_ca_t    ca;
        logic [15:0] wdata;
        logic [1:0]  wmask;
    } hbus_cmd_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        timeout;
    } hbus_rsp_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_COMMAND,
        ST_LATENCY,
        ST_WRITE,
        ST_READ,
        ST_RECOVER
    } seq_state_e;

endpackage

`default_nettype wire
